// ==== hdl/cache_geom_pkg.sv ====
// cache geometry: address split, widths and vector types, imported by every cache RTL module
package cache_geom_pkg;

    localparam int num_ways       = 4;
    localparam int num_sets       = 16;
    localparam int words_per_line = 8;

    typedef logic [31:0] addr_t;      // cpu byte address
    typedef logic [63:0] word_t;      // one cpu data word
    typedef logic [7:0]  strb_t;      // byte strobes of a word
    typedef logic [21:0] tag_t;       // addr[31:10]
    typedef logic [3:0]  index_t;     // addr[9:6]
    typedef logic [2:0]  word_sel_t;  // addr[5:3]
    typedef logic [1:0]  way_t;

    function automatic tag_t addr_tag(addr_t addr);
        return addr[31:10];
    endfunction

    function automatic index_t addr_index(addr_t addr);
        return addr[9:6];
    endfunction

    function automatic word_sel_t addr_word(addr_t addr);
        return addr[5:3];  // bits 2:0 are ignored
    endfunction

    // first byte of the line that holds tag and index
    function automatic addr_t line_addr(tag_t tag, index_t index);
        return {tag, index, 6'b0};
    endfunction

endpackage

// ==== hdl/cache_fsm_pkg.sv ====
// controller state encoding and memory burst constants, imported by the cache controller
package cache_fsm_pkg;

    typedef enum logic [2:0] {
        idle,        // waiting for a cpu request
        hit_done,    // ack cycle after a hit
        write_back,  // streaming a dirty victim out
        refill,      // loading the line from memory
        relookup     // repeat the lookup after a refill
    } ctrl_state_t;

    // beat number of the last beat of an 8-beat burst
    localparam logic [2:0] last_beat = 3'd7;

endpackage

// ==== hdl/tag_store.sv ====
// tag store: valid, dirty and tag arrays with hit lookup and victim choice for the controller
`timescale 1ns/10ps

module tag_store
    import cache_geom_pkg::*;
#(
    parameter logic [7:0] lfsr_seed = 8'd1  // any nonzero value
) (
    input  logic   clk,
    input  logic   rst,
    input  tag_t   lookup_tag,
    input  index_t lookup_index,
    input  logic   set_dirty,
    input  logic   fill_done,
    output logic   hit,
    output way_t   hit_way,
    output way_t   victim_way,
    output logic   victim_dirty,
    output tag_t   victim_tag
);

    logic [num_ways-1:0] valid_q [num_sets];
    logic [num_ways-1:0] dirty_q [num_sets];
    tag_t                tag_q   [num_sets][num_ways];

    logic [7:0] lfsr;
    logic       lfsr_fb;
    logic       set_full;
    way_t       empty_way;

    // x^8 + x^6 + x^5 + x^4 + 1
    assign lfsr_fb  = lfsr[7] ^ lfsr[5] ^ lfsr[4] ^ lfsr[3];
    assign set_full = &valid_q[lookup_index];

    // descending scan, so the lowest matching way wins
    always_comb begin
        hit     = 1'b0;
        hit_way = '0;
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (valid_q[lookup_index][w] && tag_q[lookup_index][w] == lookup_tag) begin
                hit     = 1'b1;
                hit_way = way_t'(w);
            end
        end
    end

    always_comb begin
        empty_way = '0;
        for (int w = num_ways - 1; w >= 0; w--) begin
            if (!valid_q[lookup_index][w]) begin
                empty_way = way_t'(w);
            end
        end
    end

    assign victim_way   = set_full ? lfsr[1:0] : empty_way;  // random only when full
    assign victim_dirty = valid_q[lookup_index][victim_way] & dirty_q[lookup_index][victim_way];
    assign victim_tag   = tag_q[lookup_index][victim_way];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int s = 0; s < num_sets; s++) begin
                valid_q[s] <= '0;
                dirty_q[s] <= '0;
            end
            lfsr <= lfsr_seed;
        end else begin
            if (fill_done) begin
                valid_q[lookup_index][victim_way] <= 1'b1;
                dirty_q[lookup_index][victim_way] <= 1'b0;  // fresh line is clean
                if (set_full) begin
                    lfsr <= {lfsr[6:0], lfsr_fb};
                end
            end
            if (set_dirty) begin
                dirty_q[lookup_index][hit_way] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fill_done) begin
            tag_q[lookup_index][victim_way] <= lookup_tag;
        end
    end

endmodule

// ==== hdl/data_store.sv ====
// data store: byte-strobed line RAM of all ways with a registered read, driven by the controller
`timescale 1ns/10ps

module data_store
    import cache_geom_pkg::*;
(
    input  logic      clk,
    input  way_t      ram_way,
    input  index_t    ram_index,
    input  word_sel_t ram_word,
    input  logic      ram_we,
    input  strb_t     ram_strb,
    input  word_t     ram_wdata,
    output word_t     rdata
);

    localparam int depth     = num_ways * num_sets * words_per_line;
    localparam int addr_bits = $clog2(depth);

    word_t                mem [depth];
    logic [addr_bits-1:0] ram_addr;

    assign ram_addr = {ram_way, ram_index, ram_word};  // 512 words

    always_ff @(posedge clk) begin
        if (ram_we) begin
            for (int b = 0; b < 8; b++) begin
                if (ram_strb[b]) begin
                    mem[ram_addr][8*b +: 8] <= ram_wdata[8*b +: 8];
                end
            end
        end
    end

    // old data on a write, one cycle latency
    always_ff @(posedge clk) begin
        rdata <= mem[ram_addr];
    end

endmodule

// ==== hdl/cache_ctrl.sv ====
// cache controller FSM: sequences lookup, write-back, refill and the cpu acknowledge
`timescale 1ns/10ps

module cache_ctrl
    import cache_geom_pkg::*;
    import cache_fsm_pkg::*;
(
    input  logic      clk,
    input  logic      rst,
    input  logic      cpu_req,
    input  logic      cpu_we,
    input  addr_t     cpu_addr,
    input  word_t     cpu_wdata,
    input  strb_t     cpu_wstrb,
    output logic      cpu_ack,
    output logic      mem_w_valid,
    output addr_t     mem_w_addr,
    input  logic      mem_w_ready,
    output logic      mem_r_ready,
    output addr_t     mem_r_addr,
    input  logic      mem_r_valid,
    input  word_t     mem_r_data,
    output tag_t      lookup_tag,
    output index_t    lookup_index,
    input  logic      hit,
    input  way_t      hit_way,
    input  way_t      victim_way,
    input  logic      victim_dirty,
    input  tag_t      victim_tag,
    output logic      set_dirty,
    output logic      fill_done,
    output way_t      ram_way,
    output index_t    ram_index,
    output word_sel_t ram_word,
    output logic      ram_we,
    output strb_t     ram_strb,
    output word_t     ram_wdata
);

    ctrl_state_t state;
    logic [2:0]  beat;      // beat of the running burst
    addr_t       req_addr;
    way_t        fill_way;  // victim taken at the miss
    addr_t       wb_addr;
    logic        take_req;
    logic        w_fire;
    logic        r_fire;

    assign take_req = (state == idle && cpu_req) || state == relookup;
    assign w_fire   = mem_w_valid && mem_w_ready;
    assign r_fire   = mem_r_valid && mem_r_ready;

    assign cpu_ack     = (state == hit_done);
    assign mem_w_valid = (state == write_back);
    assign mem_w_addr  = wb_addr;
    assign mem_r_ready = (state == refill);
    assign mem_r_addr  = line_addr(addr_tag(req_addr), addr_index(req_addr));

    assign set_dirty = take_req && hit && cpu_we;
    assign fill_done = r_fire && beat == last_beat;

    // live cpu address while looking up, held request during a miss
    assign lookup_tag   = take_req ? addr_tag(cpu_addr) : addr_tag(req_addr);
    assign lookup_index = take_req ? addr_index(cpu_addr) : addr_index(req_addr);

    always_comb begin
        ram_way   = fill_way;
        ram_index = addr_index(req_addr);
        ram_word  = beat;
        ram_we    = 1'b0;
        ram_strb  = '1;
        ram_wdata = mem_r_data;
        case (state)
            idle, relookup: begin
                ram_index = addr_index(cpu_addr);
                if (hit) begin
                    ram_way   = hit_way;
                    ram_word  = addr_word(cpu_addr);
                    ram_we    = take_req && cpu_we;
                    ram_strb  = cpu_wstrb;
                    ram_wdata = cpu_wdata;
                end else begin
                    ram_way  = victim_way;  // prefetch word 0 for write-back
                    ram_word = '0;
                end
            end
            write_back: begin
                if (w_fire) begin
                    ram_word = beat + 3'd1;  // next word lands as this beat leaves
                end
            end
            refill: ram_we = r_fire;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= idle;
            beat  <= '0;
        end else begin
            case (state)
                idle, relookup: begin
                    if (take_req) begin
                        beat <= '0;
                        if (hit) begin
                            state <= hit_done;
                        end else if (victim_dirty) begin
                            state <= write_back;
                        end else begin
                            state <= refill;
                        end
                    end
                end
                hit_done: state <= idle;
                write_back: begin
                    if (w_fire) begin
                        beat <= beat + 3'd1;  // wraps to 0 for refill
                        if (beat == last_beat) begin
                            state <= refill;
                        end
                    end
                end
                refill: begin
                    if (r_fire) begin
                        beat <= beat + 3'd1;
                        if (beat == last_beat) begin
                            state <= relookup;
                        end
                    end
                end
                default: state <= idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (take_req) begin
            req_addr <= cpu_addr;
            fill_way <= victim_way;
            wb_addr  <= line_addr(victim_tag, addr_index(cpu_addr));
        end
    end

endmodule

// ==== hdl/cache_top.sv ====
// data cache top level: connects controller, tag store and data store to the cpu and memory ports
`timescale 1ns/10ps

module cache_top
    import cache_geom_pkg::*;
#(
    parameter logic [7:0] lfsr_seed = 8'd1
) (
    input  logic  clk,
    input  logic  rst,
    input  logic  cpu_req,
    input  logic  cpu_we,
    input  addr_t cpu_addr,
    input  word_t cpu_wdata,
    input  strb_t cpu_wstrb,
    output logic  cpu_ack,
    output word_t cpu_rdata,
    output logic  mem_w_valid,
    output addr_t mem_w_addr,
    output word_t mem_w_data,
    input  logic  mem_w_ready,
    output logic  mem_r_ready,
    output addr_t mem_r_addr,
    input  logic  mem_r_valid,
    input  word_t mem_r_data
);

    tag_t      lookup_tag;
    index_t    lookup_index;
    logic      hit;
    way_t      hit_way;
    way_t      victim_way;
    logic      victim_dirty;
    tag_t      victim_tag;
    logic      set_dirty;
    logic      fill_done;
    way_t      ram_way;
    index_t    ram_index;
    word_sel_t ram_word;
    logic      ram_we;
    strb_t     ram_strb;
    word_t     ram_wdata;
    word_t     ram_rdata;

    assign cpu_rdata  = ram_rdata;  // valid in the ack cycle of a hit
    assign mem_w_data = ram_rdata;  // victim words during write-back

    cache_ctrl i_ctrl (
        .clk, .rst,
        .cpu_req, .cpu_we, .cpu_addr, .cpu_wdata, .cpu_wstrb, .cpu_ack,
        .mem_w_valid, .mem_w_addr, .mem_w_ready,
        .mem_r_ready, .mem_r_addr, .mem_r_valid, .mem_r_data,
        .lookup_tag, .lookup_index, .hit, .hit_way,
        .victim_way, .victim_dirty, .victim_tag, .set_dirty, .fill_done,
        .ram_way, .ram_index, .ram_word, .ram_we, .ram_strb, .ram_wdata
    );

    tag_store #(.lfsr_seed(lfsr_seed)) i_tags (
        .clk, .rst, .lookup_tag, .lookup_index, .set_dirty, .fill_done,
        .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag
    );

    data_store i_data (
        .clk, .ram_way, .ram_index, .ram_word, .ram_we, .ram_strb, .ram_wdata,
        .rdata(ram_rdata)
    );

endmodule

// ==== test/mem_model.sv ====
// behavioral memory for the cache testbench: answers 8-beat read and write bursts with random stalls
`timescale 1ns/10ps

module mem_model (
    input  logic        clk,
    input  logic        rst,
    input  logic [1:0]  stall_level,  // 0 never stalls, 3 stalls most beats
    input  logic        mem_w_valid,
    input  logic [31:0] mem_w_addr,
    input  logic [63:0] mem_w_data,
    output logic        mem_w_ready,
    input  logic        mem_r_ready,
    input  logic [31:0] mem_r_addr,
    output logic        mem_r_valid,
    output logic [63:0] mem_r_data,
    output int          wb_bursts,
    output int          wr_beats,
    output int          rd_bursts,
    output int          rd_beats
);

    logic [63:0] mem [4096];  // 32 KB window, word index addr[14:3]
    logic [2:0]  wr_beat;
    logic [2:0]  rd_beat;
    logic        in_reset;

    task automatic load_word(input logic [31:0] addr, input logic [63:0] data);
        mem[addr[14:3]] = data;
    endtask

    function automatic logic stalled(input logic [1:0] level);
        return level != 2'd0 && ($urandom % 4) < level;
    endfunction

    initial begin
        for (int i = 0; i < 4096; i++) begin
            mem[i] = {32'(i) * 32'h9e37_79b9, 32'(i << 3) ^ 32'hc0de_0000};  // whole address
        end
        mem_w_ready = 1'b0;
        mem_r_valid = 1'b0;
        mem_r_data  = '0;
        forever begin
            @(posedge clk);
            in_reset = rst;
            if (in_reset) begin
                wr_beat   = '0;
                rd_beat   = '0;
                wb_bursts = 0;
                wr_beats  = 0;
                rd_bursts = 0;
                rd_beats  = 0;
            end else begin
                if (mem_w_valid && mem_w_ready) begin
                    mem[mem_w_addr[14:3] + 12'(wr_beat)] = mem_w_data;
                    wr_beats++;
                    if (wr_beat == 3'd7) begin
                        wb_bursts++;
                    end
                    wr_beat++;
                end
                if (mem_r_valid && mem_r_ready) begin
                    rd_beats++;
                    if (rd_beat == 3'd7) begin
                        rd_bursts++;
                    end
                    rd_beat++;
                end
            end
            #1;  // outputs change just after the edge
            mem_w_ready = !in_reset && !stalled(stall_level);
            mem_r_valid = !in_reset && mem_r_ready && !stalled(stall_level);
            mem_r_data  = mem[mem_r_addr[14:3] + 12'(rd_beat)];
        end
    end

endmodule

// ==== test/tb_cache.sv ====
// testbench for the data cache: directed cpu accesses checked against a shadow of memory contents
`timescale 1ns/10ps

module tb_cache;

    localparam int num_tests    = 5;
    localparam int reset_cycles = 16;
    localparam int ack_limit    = 1500;

    logic        clk = 1'b0;
    logic        rst;
    logic        cpu_req;
    logic        cpu_we;
    logic [31:0] cpu_addr;
    logic [63:0] cpu_wdata;
    logic [7:0]  cpu_wstrb;
    logic        cpu_ack;
    logic [63:0] cpu_rdata;
    logic        mem_w_valid;
    logic [31:0] mem_w_addr;
    logic [63:0] mem_w_data;
    logic        mem_w_ready;
    logic        mem_r_ready;
    logic [31:0] mem_r_addr;
    logic        mem_r_valid;
    logic [63:0] mem_r_data;
    logic [1:0]  stall_level;
    int          wb_bursts;
    int          wr_beats;
    int          rd_bursts;
    int          rd_beats;

    logic [63:0] shadow [4096];  // expected memory, same window as the model
    logic [2:0]  wb_beat;
    int          errors;
    int          failed_tests;

    cache_top #(.lfsr_seed(8'h5a)) i_dut (
        .clk, .rst, .cpu_req, .cpu_we, .cpu_addr, .cpu_wdata, .cpu_wstrb, .cpu_ack, .cpu_rdata,
        .mem_w_valid, .mem_w_addr, .mem_w_data, .mem_w_ready,
        .mem_r_ready, .mem_r_addr, .mem_r_valid, .mem_r_data
    );

    mem_model i_mem (
        .clk, .rst, .stall_level, .mem_w_valid, .mem_w_addr, .mem_w_data, .mem_w_ready,
        .mem_r_ready, .mem_r_addr, .mem_r_valid, .mem_r_data,
        .wb_bursts, .wr_beats, .rd_bursts, .rd_beats
    );

    always #4 clk = ~clk;

    // every written-back beat must match what the cpu left in that line
    always @(posedge clk) begin
        if (rst) begin
            wb_beat <= '0;
        end else if (mem_w_valid && mem_w_ready) begin
            if (mem_w_data !== shadow[mem_w_addr[14:3] + 12'(wb_beat)]) begin
                $display("error at %0t: write-back beat %0d of line %h is %h, expected %h",
                         $time, wb_beat, mem_w_addr, mem_w_data,
                         shadow[mem_w_addr[14:3] + 12'(wb_beat)]);
                errors++;
            end
            wb_beat <= wb_beat + 3'd1;
        end
    end

    function automatic logic [31:0] make_addr(input int tag, input int index, input int word);
        return (32'(tag) << 10) | (32'(index) << 6) | (32'(word) << 3);
    endfunction

    task automatic preload_line(input int tag, input int index);
        logic [31:0] addr;
        logic [63:0] data;
        for (int w = 0; w < 8; w++) begin
            addr = make_addr(tag, index, w);
            data = {$urandom, $urandom};
            shadow[addr[14:3]] = data;
            i_mem.load_word(addr, data);
        end
    endtask

    // one request, held until the ack; cycles counts edges up to the ack cycle
    task automatic cpu_access(input logic we, input logic [31:0] addr, input logic [63:0] wdata,
                              input logic [7:0] wstrb, output logic [63:0] rdata,
                              output int cycles);
        int n;
        n = 0;
        @(posedge clk);
        #1;
        cpu_req   = 1'b1;
        cpu_we    = we;
        cpu_addr  = addr;
        cpu_wdata = wdata;
        cpu_wstrb = wstrb;
        do begin
            @(posedge clk);
            #1;
            n++;
        end while (!cpu_ack && n < ack_limit);
        rdata  = cpu_rdata;
        cycles = n;
        if (!cpu_ack) begin
            $display("no acknowledge for the access to %h within %0d cycles", addr, ack_limit);
            errors++;
        end
        cpu_req = 1'b0;
        cpu_we  = 1'b0;
    endtask

    task automatic cpu_write(input logic [31:0] addr, input logic [63:0] data,
                             input logic [7:0] strb, output int cycles);
        logic [63:0] unused;
        cpu_access(1'b1, addr, data, strb, unused, cycles);
        for (int b = 0; b < 8; b++) begin
            if (strb[b]) begin
                shadow[addr[14:3]][8*b +: 8] = data[8*b +: 8];
            end
        end
    endtask

    task automatic check_read(input logic [31:0] addr, output int cycles);
        logic [63:0] data;
        cpu_access(1'b0, addr, '0, '0, data, cycles);
        if (data !== shadow[addr[14:3]]) begin
            $display("error at %0t: read of %h returned %h, expected %h",
                     $time, addr, data, shadow[addr[14:3]]);
            errors++;
        end
    endtask

    task automatic check_latency(input int cycles, input logic expect_hit, input logic [31:0] addr);
        if (expect_hit ? cycles != 1 : cycles < 2) begin
            $display("error at %0t: access to %h acked after %0d cycles, expected a %s",
                     $time, addr, cycles, expect_hit ? "hit" : "miss");
            errors++;
        end
    endtask

    task automatic report_test(input string name, input int err_start);
        if (errors == err_start) begin
            $display("test %s passed", name);
        end else begin
            $display("test %s failed with %0d errors", name, errors - err_start);
            failed_tests++;
        end
    endtask

    task automatic test_read_miss_hit();
        int err_start;
        int cycles;
        err_start = errors;
        preload_line(1, 3);
        check_read(make_addr(1, 3, 2), cycles);
        check_latency(cycles, 1'b0, make_addr(1, 3, 2));
        check_read(make_addr(1, 3, 2), cycles);
        check_latency(cycles, 1'b1, make_addr(1, 3, 2));  // ack one cycle after sampling
        report_test("read miss then hit", err_start);
    endtask

    task automatic test_write_strobes();
        int err_start;
        int cycles;
        err_start = errors;
        cpu_write(make_addr(1, 3, 5), {$urandom, $urandom}, 8'b1010_0110, cycles);
        check_latency(cycles, 1'b1, make_addr(1, 3, 5));
        check_read(make_addr(1, 3, 5), cycles);  // unstrobed bytes keep the preload
        report_test("strobed write hit", err_start);
    endtask

    task automatic test_set_replace();
        int err_start;
        int cycles;
        err_start = errors;
        for (int t = 2; t < 7; t++) begin
            preload_line(t, 7);
        end
        for (int t = 2; t < 6; t++) begin
            check_read(make_addr(t, 7, t), cycles);
        end
        for (int t = 2; t < 6; t++) begin
            check_read(make_addr(t, 7, t), cycles);
            check_latency(cycles, 1'b1, make_addr(t, 7, t));  // all four ways resident
        end
        check_read(make_addr(6, 7, 1), cycles);
        check_latency(cycles, 1'b0, make_addr(6, 7, 1));
        for (int t = 2; t < 7; t++) begin
            check_read(make_addr(t, 7, 0), cycles);
            check_read(make_addr(t, 7, 7), cycles);
        end
        report_test("set fill and replacement", err_start);
    endtask

    task automatic test_dirty_evict();
        int err_start;
        int cycles;
        int bursts_start;
        err_start = errors;
        for (int t = 8; t < 14; t++) begin
            preload_line(t, 11);
        end
        cpu_write(make_addr(8, 11, 3), {$urandom, $urandom}, 8'hff, cycles);
        bursts_start = wb_bursts;
        for (int i = 0; i < 60 && wb_bursts == bursts_start; i++) begin
            check_read(make_addr(9 + i % 5, 11, i % 8), cycles);
        end
        if (wb_bursts == bursts_start) begin
            $display("the dirty line was never written back within 60 accesses");
            errors++;
        end
        check_read(make_addr(8, 11, 3), cycles);
        check_latency(cycles, 1'b0, make_addr(8, 11, 3));  // comes back from memory
        report_test("dirty write-back", err_start);
    endtask

    task automatic test_stalled_bursts();
        int err_start;
        int cycles;
        int rd_bursts_start;
        int rd_beats_start;
        int wb_bursts_start;
        int wr_beats_start;
        err_start       = errors;
        rd_bursts_start = rd_bursts;
        rd_beats_start  = rd_beats;
        wb_bursts_start = wb_bursts;
        wr_beats_start  = wr_beats;
        stall_level     = 2'd3;
        for (int t = 16; t < 22; t++) begin
            preload_line(t, 2);
        end
        for (int r = 0; r < 2; r++) begin
            for (int t = 16; t < 22; t++) begin
                cpu_write(make_addr(t, 2, r + 1), {$urandom, $urandom}, 8'hff, cycles);
                check_read(make_addr(t, 2, r + 1), cycles);
                check_read(make_addr(t, 2, 7 - r), cycles);
            end
        end
        stall_level = 2'd1;
        if (rd_bursts == rd_bursts_start
            || rd_beats - rd_beats_start != 8 * (rd_bursts - rd_bursts_start)) begin
            $display("error at %0t: %0d read beats in %0d refill bursts", $time,
                     rd_beats - rd_beats_start, rd_bursts - rd_bursts_start);
            errors++;
        end
        if (wb_bursts == wb_bursts_start
            || wr_beats - wr_beats_start != 8 * (wb_bursts - wb_bursts_start)) begin
            $display("error at %0t: %0d write beats in %0d write-back bursts", $time,
                     wr_beats - wr_beats_start, wb_bursts - wb_bursts_start);
            errors++;
        end
        report_test("bursts under stalls", err_start);
    endtask

    initial begin
        repeat (reset_cycles + num_tests * 2000) @(posedge clk);
        $display("timeout: the tests did not finish within %0d cycles", num_tests * 2000);
        $display("STATUS: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'h42e2));
        rst          = 1'b1;
        cpu_req      = 1'b0;
        cpu_we       = 1'b0;
        cpu_addr     = '0;
        cpu_wdata    = '0;
        cpu_wstrb    = '0;
        stall_level  = 2'd1;  // light stalls by default
        errors       = 0;
        failed_tests = 0;
        repeat (reset_cycles) @(posedge clk);
        #1;
        rst = 1'b0;
        test_read_miss_hit();
        test_write_strobes();
        test_set_replace();
        test_dirty_evict();
        test_stalled_bursts();
        repeat (4) @(posedge clk);
        $display("tests run %0d, tests failed %0d, errors %0d", num_tests, failed_tests, errors);
        if (errors == 0) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
hdl/cache_geom_pkg.sv
hdl/cache_fsm_pkg.sv
hdl/tag_store.sv
hdl/data_store.sv
hdl/cache_ctrl.sv
hdl/cache_top.sv
test/mem_model.sv
test/tb_cache.sv

// ==== Bender.yml ====
package:
  name: data_cache

sources:
  - files:
      - hdl/cache_geom_pkg.sv
      - hdl/cache_fsm_pkg.sv
      - hdl/tag_store.sv
      - hdl/data_store.sv
      - hdl/cache_ctrl.sv
      - hdl/cache_top.sv
  - target: test
    files:
      - test/mem_model.sv
      - test/tb_cache.sv
